//--- include/vlsu_params.svh
// ============================
// Sizing macros for the VLSU control machine
// Beat bytes follow the data width and must be a power of two
// A burst is limited to VLSU_MAX_BEATS and to one VLSU_PAGE_BYTES page
// ============================
`ifndef VLSU_PARAMS_SVH
`define VLSU_PARAMS_SVH

// Address and data
`define VLSU_ADDR_W 32
`define VLSU_DATA_W 64
`define VLSU_BEAT_BYTES (`VLSU_DATA_W / 8)

// Burst shaping
`define VLSU_MAX_BEATS 16
`define VLSU_PAGE_BYTES 4096
`define VLSU_LEN_W 12

// Flow control and bookkeeping
`define VLSU_META_CREDITS 4
`define VLSU_WR_CNT_W 8

`endif

//--- rtl/vlsu_pkg.sv
// ============================
// Shared types of the VLSU control machine
// AR and AW use the same address beat format
// ============================
`default_nettype none

`include "vlsu_params.svh"

package vlsu_pkg;

    // Width that holds a burst length of 1 to VLSU_MAX_BEATS
    localparam int unsigned BURST_BEATS_W = $clog2(`VLSU_MAX_BEATS + 1);

    // AXI encodings
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE       = 3'($clog2(`VLSU_BEAT_BYTES));

    typedef struct packed {
        logic [`VLSU_ADDR_W-1:0] addr;
        logic [`VLSU_LEN_W-1:0]  beats;
        logic                    is_store;
    } vlsu_req_t;

    // One record per burst, sent to the data controller
    typedef struct packed {
        logic [`VLSU_ADDR_W-1:0]  addr;
        logic [BURST_BEATS_W-1:0] beats;
        logic                     is_store;
        logic                     last;
    } meta_t;

    typedef struct packed {
        logic [`VLSU_ADDR_W-1:0] addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
    } axi_addr_t;

endpackage

`default_nettype wire

//--- rtl/credit_counter.sv
// ============================
// Metadata credit pool toward the data controller
// Starts full and never grows past the initial credit count
// ============================
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_params.svh"

module credit_counter (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic take_i,
    input  wire logic return_i,
    output logic      avail_o
);

    localparam int unsigned CNT_W = $clog2(`VLSU_META_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(`VLSU_META_CREDITS);

    logic [CNT_W-1:0] cnt_q;

    // A take and a return in one cycle cancel out
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= CNT_INIT;
        end else if (take_i && !return_i) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end else if (return_i && !take_i) begin
            if (cnt_q != CNT_INIT) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign avail_o = (cnt_q != '0);

endmodule

`default_nettype wire

//--- rtl/req_fragmenter.sv
// ============================
// Cuts one vector request into AXI bursts
// Base address must be aligned to the beat size and beats nonzero
// Loads wait until no store is pending in the core or in this unit
// ============================
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_params.svh"

module req_fragmenter import vlsu_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      req_valid_i,
    input  wire vlsu_req_t req_i,
    input  wire logic      core_st_pending_i,
    input  wire logic      writes_pending_i,
    input  wire logic      credit_avail_i,
    input  wire logic      frag_ready_i,
    output logic           req_ready_o,
    output logic           frag_valid_o,
    output meta_t          frag_meta_o,
    output logic           credit_take_o
);

    localparam int unsigned PAGE_W     = $clog2(`VLSU_PAGE_BYTES);
    localparam int unsigned BEAT_SHIFT = $clog2(`VLSU_BEAT_BYTES);
    localparam logic [BURST_BEATS_W-1:0] MAX_BEATS = BURST_BEATS_W'(`VLSU_MAX_BEATS);

    typedef enum logic {
        IDLE,
        SPLIT
    } state_e;

    state_e                   state_q;
    logic [`VLSU_ADDR_W-1:0]  addr_q;
    logic [`VLSU_LEN_W-1:0]   rem_q;
    logic                     store_q;

    logic                     accept;
    logic                     fire;
    logic [PAGE_W:0]          page_left;
    logic [PAGE_W:0]          page_beats;
    logic [BURST_BEATS_W-1:0] rem_cap;
    logic [BURST_BEATS_W-1:0] page_cap;
    logic [BURST_BEATS_W-1:0] burst_beats;
    logic                     burst_last;

    // ==========================
    // Acceptance
    // ==========================
    // Stores always pass, loads wait for every older store
    assign req_ready_o = (state_q == IDLE) &&
                         (req_i.is_store || (!core_st_pending_i && !writes_pending_i));
    assign accept      = req_valid_i && req_ready_o;

    // ==========================
    // Burst length
    // ==========================
    // Bytes and then beats left before the next page boundary
    assign page_left  = (PAGE_W+1)'(`VLSU_PAGE_BYTES) - {1'b0, addr_q[PAGE_W-1:0]};
    assign page_beats = page_left >> BEAT_SHIFT;

    assign rem_cap  = (rem_q > `VLSU_LEN_W'(MAX_BEATS)) ? MAX_BEATS
                                                         : rem_q[BURST_BEATS_W-1:0];
    assign page_cap = (page_beats > (PAGE_W+1)'(MAX_BEATS)) ? MAX_BEATS
                                                             : page_beats[BURST_BEATS_W-1:0];

    assign burst_beats = (rem_cap < page_cap) ? rem_cap : page_cap;
    assign burst_last  = (rem_q == `VLSU_LEN_W'(burst_beats));

    // ==========================
    // Emission
    // ==========================
    // A burst is offered only while a metadata credit is available
    assign frag_valid_o  = (state_q == SPLIT) && credit_avail_i;
    assign fire          = frag_valid_o && frag_ready_i;
    assign credit_take_o = fire;

    assign frag_meta_o = '{
        addr:     addr_q,
        beats:    burst_beats,
        is_store: store_q,
        last:     burst_last
    };

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else if (accept) begin
            state_q <= SPLIT;
        end else if (fire && burst_last) begin
            state_q <= IDLE;
        end
    end

    // Walking address and remaining beats
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= req_i.addr;
            rem_q   <= req_i.beats;
            store_q <= req_i.is_store;
        end else if (fire) begin
            addr_q <= addr_q + (`VLSU_ADDR_W'(burst_beats) << BEAT_SHIFT);
            rem_q  <= rem_q - `VLSU_LEN_W'(burst_beats);
        end
    end

endmodule

`default_nettype wire

//--- rtl/txn_ctrl_unit.sv
// ============================
// One-entry AR/AW issue stage and outstanding write counter
// B responses are always accepted and never carry errors
// ============================
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_params.svh"

module txn_ctrl_unit import vlsu_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_n_i,
    input  wire logic  frag_valid_i,
    input  wire meta_t frag_meta_i,
    input  wire logic  ar_ready_i,
    input  wire logic  aw_ready_i,
    input  wire logic  b_valid_i,
    output logic       frag_ready_o,
    output logic       ar_valid_o,
    output axi_addr_t  ar_o,
    output logic       aw_valid_o,
    output axi_addr_t  aw_o,
    output logic       b_ready_o,
    output logic       writes_pending_o
);

    logic                      valid_q;
    logic                      store_q;
    axi_addr_t                 beat_q;
    logic                      load_stage;
    logic                      issued;
    logic                      aw_done;
    logic [BURST_BEATS_W-1:0]  len_m1;
    logic [`VLSU_WR_CNT_W-1:0] wr_cnt_q;

    // ==========================
    // Issue stage
    // ==========================
    assign issued       = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
    assign frag_ready_o = !valid_q || issued;
    assign load_stage   = frag_valid_i && frag_ready_o;
    assign len_m1       = frag_meta_i.beats - 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (load_stage) begin
            valid_q <= 1'b1;
        end else if (issued) begin
            valid_q <= 1'b0;
        end
    end

    // Address beat is built once and held until the handshake
    always_ff @(posedge clk_i) begin
        if (load_stage) begin
            store_q      <= frag_meta_i.is_store;
            beat_q.addr  <= frag_meta_i.addr;
            beat_q.len   <= 8'(len_m1);
            beat_q.size  <= AXI_SIZE;
            beat_q.burst <= AXI_BURST_INCR;
        end
    end

    assign ar_valid_o = valid_q && !store_q;
    assign aw_valid_o = valid_q && store_q;
    assign ar_o       = beat_q;
    assign aw_o       = beat_q;

    // ==========================
    // Outstanding writes
    // ==========================
    assign b_ready_o = 1'b1;
    assign aw_done   = aw_valid_o && aw_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_cnt_q <= '0;
        end else if (aw_done && !b_valid_i) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
        end else if (b_valid_i && !aw_done) begin
            wr_cnt_q <= wr_cnt_q - 1'b1;
        end
    end

    // A store still waiting in the stage counts as pending too
    assign writes_pending_o = (wr_cnt_q != '0) || aw_valid_o;

endmodule

`default_nettype wire

//--- rtl/control_machine.sv
// ============================
// VLSU control machine top level
// Metadata goes out as a one-cycle pulse paced by credits
// ============================
`timescale 1ns/1ps
`default_nettype none

module control_machine import vlsu_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    // Requester
    input  wire logic      req_valid_i,
    output logic           req_ready_o,
    input  wire vlsu_req_t req_i,
    input  wire logic      core_st_pending_i,
    // Data controller
    output logic           meta_valid_o,
    output meta_t          meta_o,
    input  wire logic      credit_return_i,
    // AXI address and write response
    output logic           ar_valid_o,
    input  wire logic      ar_ready_i,
    output axi_addr_t      ar_o,
    output logic           aw_valid_o,
    input  wire logic      aw_ready_i,
    output axi_addr_t      aw_o,
    input  wire logic      b_valid_i,
    output logic           b_ready_o
);

    logic  credit_avail;
    logic  credit_take;
    logic  frag_valid;
    logic  frag_ready;
    meta_t frag_meta;
    logic  writes_pending;

    req_fragmenter req_fragmenter_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .req_valid_i       (req_valid_i),
        .req_i             (req_i),
        .core_st_pending_i (core_st_pending_i),
        .writes_pending_i  (writes_pending),
        .credit_avail_i    (credit_avail),
        .frag_ready_i      (frag_ready),
        .req_ready_o       (req_ready_o),
        .frag_valid_o      (frag_valid),
        .frag_meta_o       (frag_meta),
        .credit_take_o     (credit_take)
    );

    credit_counter credit_counter_inst (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .take_i   (credit_take),
        .return_i (credit_return_i),
        .avail_o  (credit_avail)
    );

    txn_ctrl_unit txn_ctrl_unit_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .frag_valid_i     (frag_valid),
        .frag_meta_i      (frag_meta),
        .ar_ready_i       (ar_ready_i),
        .aw_ready_i       (aw_ready_i),
        .b_valid_i        (b_valid_i),
        .frag_ready_o     (frag_ready),
        .ar_valid_o       (ar_valid_o),
        .ar_o             (ar_o),
        .aw_valid_o       (aw_valid_o),
        .aw_o             (aw_o),
        .b_ready_o        (b_ready_o),
        .writes_pending_o (writes_pending)
    );

    // Every burst handed to the issue stage is also reported downstream
    assign meta_valid_o = credit_take;
    assign meta_o       = frag_meta;

endmodule

`default_nettype wire

//--- verif/control_machine_tb.sv
// ============================
// Directed testbench for the VLSU control machine
// Models a credit-returning data controller and an AXI slave with delayed B
// Outputs are sampled 1 ns after the falling edge, before the next rising edge
// ============================
`timescale 1ns/1ps
`default_nettype none

`include "vlsu_params.svh"

module control_machine_tb import vlsu_pkg::*;;

    localparam int TIMEOUT   = 500;
    localparam int RET_DELAY = 3;
    localparam int B_DELAY   = 4;

    logic      clk_i             = 1'b0;
    logic      rst_n_i           = 1'b0;
    logic      req_valid_i       = 1'b0;
    vlsu_req_t req_i             = '0;
    logic      core_st_pending_i = 1'b0;
    logic      credit_return_i   = 1'b0;
    logic      ar_ready_i        = 1'b1;
    logic      aw_ready_i        = 1'b1;
    logic      b_valid_i         = 1'b0;
    logic      req_ready_o;
    logic      meta_valid_o;
    logic      ar_valid_o;
    logic      aw_valid_o;
    logic      b_ready_o;
    meta_t     meta_o;
    axi_addr_t ar_o;
    axi_addr_t aw_o;

    // Model controls and bookkeeping
    logic      credit_en = 1'b1;
    logic      b_hold    = 1'b0;
    logic      rand_mode = 1'b0;
    integer    seed      = 32'hf01e;
    int        cyc       = 0;
    int        last_cnt  = 0;
    int        last_seen = 0;
    int        ret_cnt   = 0;
    int        b_cnt     = 0;
    int        meta_base = 0;
    int        ar_base   = 0;
    int        aw_base   = 0;
    int        errors    = 0;
    int        timeouts  = 0;
    meta_t     meta_q[$];
    axi_addr_t ar_q[$];
    axi_addr_t aw_q[$];
    int        meta_time[$];
    int        aw_time[$];

    control_machine control_machine_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .req_valid_i       (req_valid_i),
        .req_ready_o       (req_ready_o),
        .req_i             (req_i),
        .core_st_pending_i (core_st_pending_i),
        .meta_valid_o      (meta_valid_o),
        .meta_o            (meta_o),
        .credit_return_i   (credit_return_i),
        .ar_valid_o        (ar_valid_o),
        .ar_ready_i        (ar_ready_i),
        .ar_o              (ar_o),
        .aw_valid_o        (aw_valid_o),
        .aw_ready_i        (aw_ready_i),
        .aw_o              (aw_o),
        .b_valid_i         (b_valid_i),
        .b_ready_o         (b_ready_o)
    );

    always #5 clk_i = ~clk_i;

    // Collects meta records and AR/AW handshakes
    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (meta_valid_o) begin
            meta_q.push_back(meta_o);
            meta_time.push_back(cyc);
            if (meta_o.last) begin
                last_cnt <= last_cnt + 1;
            end
        end
        if (ar_valid_o && ar_ready_i) begin
            ar_q.push_back(ar_o);
        end
        if (aw_valid_o && aw_ready_i) begin
            aw_q.push_back(aw_o);
            aw_time.push_back(cyc);
        end
    end

    // Data controller and AXI slave models
    always @(negedge clk_i) begin
        int rnd;
        rnd        = $random(seed);
        ar_ready_i = rand_mode ? rnd[0] : 1'b1;
        aw_ready_i = rand_mode ? rnd[1] : 1'b1;
        if (credit_en && ret_cnt < meta_time.size() && meta_time[ret_cnt] + RET_DELAY <= cyc) begin
            credit_return_i = 1'b1;
            ret_cnt++;
        end else begin
            credit_return_i = 1'b0;
        end
        if (!b_hold && b_cnt < aw_time.size() && aw_time[b_cnt] + B_DELAY <= cyc) begin
            b_valid_i = 1'b1;
            b_cnt++;
        end else begin
            b_valid_i = 1'b0;
        end
    end

    // ============================
    // Driver and checker tasks
    // ============================
    task automatic check(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp) begin
            errors++;
            $display("ERROR @%0t: %s: got %0h, expected %0h", $time, what, act, exp);
        end
    endtask

    task automatic drive_req(input logic [31:0] addr, input int beats, input logic st);
        @(negedge clk_i);
        req_valid_i    = 1'b1;
        req_i.addr     = addr;
        req_i.beats    = `VLSU_LEN_W'(beats);
        req_i.is_store = st;
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic await_accept(input string name);
        int   t;
        logic done;
        t    = 0;
        done = 1'b0;
        while (!done && t < TIMEOUT) begin
            #1;
            done = req_ready_o;
            @(negedge clk_i);
            t++;
        end
        req_valid_i = 1'b0;
        if (!done) begin
            timeouts++;
            $display("%s: the request was never accepted", name);
        end
    endtask

    task automatic hold_off(input string name);
        repeat (8) begin
            #1;
            check(32'(req_ready_o), 0, {name, " req_ready_o"});
            check(32'(ar_valid_o), 0, {name, " ar_valid_o"});
            @(negedge clk_i);
        end
    endtask

    // Waits for the last burst to leave the issue stage, checking stalled beats
    task automatic wait_done(input string name);
        int        t;
        logic      done;
        logic      ar_hold;
        logic      aw_hold;
        axi_addr_t ar_prev;
        axi_addr_t aw_prev;
        t       = 0;
        done    = 1'b0;
        ar_hold = 1'b0;
        aw_hold = 1'b0;
        while (!done && t < TIMEOUT) begin
            @(negedge clk_i);
            #1;
            if (ar_hold) begin
                check(32'(ar_valid_o), 1, {name, " AR valid dropped while stalled"});
                check(32'(ar_o != ar_prev), 0, {name, " AR beat changed while stalled"});
            end
            if (aw_hold) begin
                check(32'(aw_valid_o), 1, {name, " AW valid dropped while stalled"});
                check(32'(aw_o != aw_prev), 0, {name, " AW beat changed while stalled"});
            end
            ar_hold = ar_valid_o && !ar_ready_i;
            aw_hold = aw_valid_o && !aw_ready_i;
            ar_prev = ar_o;
            aw_prev = aw_o;
            done    = (last_cnt > last_seen) && !ar_valid_o && !aw_valid_o;
            t++;
        end
        if (!done) begin
            timeouts++;
            $display("%s: the request did not finish in time", name);
        end
        last_seen = last_cnt;
    endtask

    // Walks the burst rule and compares meta records and AXI beats
    task automatic verify_req(input logic [31:0] base, input int beats, input logic st,
                              input string name);
        logic [31:0] a;
        int          rem;
        int          n;
        int          room;
        int          idx;
        axi_addr_t   beat;
        a   = base;
        rem = beats;
        idx = 0;
        while (rem > 0) begin
            room = (`VLSU_PAGE_BYTES - int'(a % `VLSU_PAGE_BYTES)) / `VLSU_BEAT_BYTES;
            n    = (rem < `VLSU_MAX_BEATS) ? rem : `VLSU_MAX_BEATS;
            n    = (n < room) ? n : room;
            if (meta_base + idx < meta_q.size()) begin
                check(meta_q[meta_base + idx].addr, a, {name, " meta addr"});
                check(32'(meta_q[meta_base + idx].beats), n, {name, " meta beats"});
                check(32'(meta_q[meta_base + idx].is_store), 32'(st), {name, " meta is_store"});
                check(32'(meta_q[meta_base + idx].last), 32'(rem == n), {name, " meta last"});
            end
            if (st ? (aw_base + idx < aw_q.size()) : (ar_base + idx < ar_q.size())) begin
                beat = st ? aw_q[aw_base + idx] : ar_q[ar_base + idx];
                check(beat.addr, a, {name, " burst addr"});
                check(32'(beat.len), n - 1, {name, " burst len"});
                // AXI size encodes bytes per beat as a power of two
                check(32'(1) << beat.size, `VLSU_BEAT_BYTES, {name, " burst size"});
                check(32'(beat.burst), 1, {name, " burst type"});
            end
            a   = a + n * `VLSU_BEAT_BYTES;
            rem = rem - n;
            idx++;
        end
        check(meta_q.size() - meta_base, idx, {name, " meta count"});
        check(ar_q.size() - ar_base, st ? 0 : idx, {name, " AR count"});
        check(aw_q.size() - aw_base, st ? idx : 0, {name, " AW count"});
        meta_base = meta_q.size();
        ar_base   = ar_q.size();
        aw_base   = aw_q.size();
    endtask

    task automatic run_req(input logic [31:0] addr, input int beats, input logic st,
                           input string name);
        drive_req(addr, beats, st);
        await_accept(name);
        wait_done(name);
        verify_req(addr, beats, st, name);
    endtask

    // ============================
    // Tests
    // ============================
    task automatic short_load_test();
        run_req(32'h0000_1000, 5, 1'b0, "short load");
    endtask

    task automatic long_store_test();
        run_req(32'h0000_2000, 40, 1'b1, "long store");
    endtask

    task automatic page_cross_test();
        run_req(32'h0000_2FE8, 10, 1'b0, "page boundary");
    endtask

    task automatic credit_stall_test();
        int t;
        t = 0;
        while (ret_cnt < meta_q.size() && t < TIMEOUT) begin
            @(posedge clk_i);
            t++;
        end
        if (ret_cnt < meta_q.size()) begin
            timeouts++;
            $display("credits: earlier credits were never returned");
        end
        @(posedge clk_i);
        credit_en = 1'b0;
        drive_req(32'h0000_4000, 100, 1'b0);
        await_accept("credits");
        repeat (30) @(negedge clk_i);
        #1;
        check(meta_q.size() - meta_base, `VLSU_META_CREDITS, "credits meta count while stalled");
        check(32'(req_ready_o), 0, "credits req_ready_o while busy");
        @(posedge clk_i);
        credit_en = 1'b1;
        wait_done("credits");
        verify_req(32'h0000_4000, 100, 1'b0, "credits");
    endtask

    task automatic ordering_test();
        @(negedge clk_i);
        core_st_pending_i = 1'b1;
        drive_req(32'h0000_9000, 8, 1'b0);
        hold_off("load behind core store");
        core_st_pending_i = 1'b0;
        await_accept("load behind core store");
        wait_done("load behind core store");
        verify_req(32'h0000_9000, 8, 1'b0, "load behind core store");
        // B responses held back keep the store outstanding
        @(posedge clk_i);
        b_hold = 1'b1;
        run_req(32'h0000_A000, 8, 1'b1, "held store");
        drive_req(32'h0000_B000, 8, 1'b0);
        hold_off("load behind held store");
        @(posedge clk_i);
        b_hold = 1'b0;
        @(negedge clk_i);
        await_accept("load behind held store");
        wait_done("load behind held store");
        verify_req(32'h0000_B000, 8, 1'b0, "load behind held store");
    endtask

    task automatic backpressure_test();
        @(posedge clk_i);
        rand_mode = 1'b1;
        run_req(32'h0000_6FC0, 50, 1'b0, "random ready load");
        run_req(32'h0000_8000, 30, 1'b1, "random ready store");
        @(posedge clk_i);
        rand_mode = 1'b0;
    endtask

    initial begin
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        check(32'(req_ready_o), 1, "req_ready_o after reset");
        check(32'({meta_valid_o, ar_valid_o, aw_valid_o}), 0, "valids after reset");
        check(32'(b_ready_o), 1, "b_ready_o after reset");
        short_load_test();
        long_store_test();
        page_cross_test();
        credit_stall_test();
        ordering_test();
        backpressure_test();
        $display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
rtl/vlsu_pkg.sv
rtl/credit_counter.sv
rtl/req_fragmenter.sv
rtl/txn_ctrl_unit.sv
rtl/control_machine.sv
verif/control_machine_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the control machine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f \
    --top-module control_machine_tb -o control_machine_sim

out="$(./obj_dir/control_machine_sim)"
echo "$out"

# Pass only if the testbench printed the pass message
echo "$out" | grep -q "NO ERRORS"
